// ==== Makefile ====
VERILATOR ?= verilator
TOP       := usb_tx_tb
FILELIST  := usb_tx_top.f
FLAGS     := --timing
OBJ_DIR   := obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/usb_tx_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usb_tx_defs.svh"

module usb_tx_monitor (
  input  logic              clock,
  input  logic              reset,
  input  logic              req,
  input  logic              ack,
  input  logic              pid_error,
  input  logic              busy,
  input  usb_tx_pkg::line_t line,
  input  logic              exp_valid,
  input  logic [7:0]        exp_data,
  input  logic              exp_last,
  input  logic              exp_err,
  output int                done_count,
  output int                error_count,
  output int                pending_count,
  output int                stall_count
);

  localparam int MID = `USB_BIT_CYCLES / 2;

  typedef enum logic [1:0] {D_LEAD, D_DATA, D_EOP, D_TAIL} dec_t;

  logic [8:0] exp_q [$];  // last flag above the byte
  logic [7:0] rx_q [$];
  int         err_pending;
  int         err_acks;   // acks left in the bad packet
  int         n_done;
  int         n_err;
  int         req_wait;
  int         stalls;
  logic       ack_q;
  logic       reset_checked;
  logic       active;
  dec_t       dstate;
  int         cyc;
  logic       prev_lvl;   // high is J
  int         ones;
  int         nbits;
  int         stuffed;
  int         se0_bits;
  int         j_bits;
  logic [7:0] cur;

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
      n_err++;
    end
  endtask

  task automatic report_error(input string what);
    $display("error at %0t: %s", $time, what);
    n_err++;
  endtask

  task automatic compare_packet();
    logic [7:0]  e [$];
    logic [8:0]  x;
    logic [15:0] crc;
    logic        fb;
    int          errs_before;
    errs_before = n_err;
    if (nbits != 0)
      report_error($sformatf("packet ended %0d bits into a byte", nbits));
    if (rx_q.size() == 0) begin
      report_error("packet on the line carried no SYNC");
    end else begin
      check_value("line sync byte", int'(`USB_SYNC_BYTE), int'(rx_q[0]));
      void'(rx_q.pop_front());
    end
    if (exp_q.size() == 0) begin
      report_error("packet on the line with no packet expected");
    end else begin
      do begin
        x = exp_q.pop_front();
        e.push_back(x[7:0]);
      end while (!x[8] && exp_q.size() != 0);
      // data pids carry crc16 over the payload, sent inverted
      if (e[0][1:0] == `USB_PID_TYPE_DATA) begin
        crc = `USB_CRC16_INIT;
        for (int i = 1; i < e.size(); i++) begin
          for (int k = 0; k < 8; k++) begin
            fb  = crc[0] ^ e[i][k];
            crc = crc >> 1;
            if (fb)
              crc = crc ^ `USB_CRC16_POLY;
          end
        end
        e.push_back(~crc[7:0]);
        e.push_back(~crc[15:8]);
      end
      check_value("line byte count", e.size(), rx_q.size());
      for (int i = 0; i < e.size() && i < rx_q.size(); i++)
        check_value($sformatf("line byte %0d", i), int'(e[i]), int'(rx_q[i]));
    end
    n_done++;
    $display("test %0d: %0d bytes after sync, %0d stuffed zeros, %s", n_done,
             rx_q.size(), stuffed, (n_err == errs_before) ? "ok" : "failed");
  endtask

  task automatic sample_bit();
    logic b;
    if (dstate == D_LEAD) begin
      check_value("line lead dp", 1, int'(line.dp));
      check_value("line lead dm", 0, int'(line.dm));
      prev_lvl = 1'b1;
      dstate   = D_DATA;
    end else if (!line.dp && !line.dm) begin
      if (dstate == D_DATA) begin
        compare_packet();
        dstate = D_EOP;
      end else if (dstate == D_TAIL) begin
        report_error("SE0 after the closing J");
      end
      se0_bits++;
    end else if (line.dp && line.dm) begin
      report_error("line shows dp and dm both high");
    end else if (dstate == D_DATA) begin
      b        = (line.dp == prev_lvl);  // no transition is a one
      prev_lvl = line.dp;
      if (ones == `USB_STUFF_LIMIT) begin
        if (b)
          report_error("seventh one in a row, stuffed zero missing");
        else
          stuffed++;
        ones = 0;
      end else begin
        ones  = b ? ones + 1 : 0;
        cur   = {b, cur[7:1]};
        nbits = nbits + 1;
        if (nbits == 8) begin
          rx_q.push_back(cur);
          nbits = 0;
        end
      end
    end else begin
      if (!line.dp)
        report_error("K seen where the closing J belongs");
      j_bits++;
      dstate = D_TAIL;
    end
  endtask

  task automatic end_packet();
    if (dstate == D_LEAD || dstate == D_DATA) begin
      report_error("line released before EOP");
      compare_packet();
    end
    check_value("eop se0 bit times", 2, se0_bits);
    check_value("closing j bit times", 1, j_bits);
    active = 1'b0;
  endtask

  always @(posedge clock) begin
    if (reset) begin
      exp_q.delete();
      rx_q.delete();
      err_pending   = 0;
      err_acks      = 0;
      n_done        = 0;
      n_err         = 0;
      req_wait      = 0;
      stalls        = 0;
      ack_q         = 1'b0;
      reset_checked = 1'b0;
      active        = 1'b0;
    end else begin
      if (!reset_checked) begin
        check_value("ack after reset", 0, int'(ack));
        check_value("busy after reset", 0, int'(busy));
        check_value("pid_error after reset", 0, int'(pid_error));
        check_value("line.drive after reset", 0, int'(line.drive));
        reset_checked = 1'b1;
      end
      if (exp_valid) begin
        if (exp_err) begin
          err_pending++;
          err_acks = int'(exp_data);  // acks owed, length byte included
        end else begin
          exp_q.push_back({exp_last, exp_data});
        end
      end
      if (pid_error) begin
        if (err_pending == 0) begin
          report_error("pid_error pulsed for a packet with a good PID");
        end else begin
          err_pending--;
          if (!(ack && !ack_q) || err_acks != 1)
            report_error("pid_error not at the last ack of the bad packet");
          n_done++;
          $display("test %0d: bad pid rejected with pid_error", n_done);
        end
      end
      if (ack && !ack_q && err_acks > 0)
        err_acks--;
      // back-pressure shows as ack arriving late
      if (ack && !ack_q && req_wait > 1)
        stalls += req_wait - 1;
      if (req && !ack)
        req_wait++;
      else
        req_wait = 0;
      ack_q = ack;

      if (line.drive && !busy)
        report_error("line driven while busy is low");
      if (!active && line.drive) begin
        if (exp_q.size() == 0)
          report_error("line driven with no packet queued");
        active   = 1'b1;
        dstate   = D_LEAD;
        cyc      = 0;
        ones     = 0;
        nbits    = 0;
        stuffed  = 0;
        se0_bits = 0;
        j_bits   = 0;
        rx_q.delete();
      end
      if (active) begin
        if (!line.drive) begin
          end_packet();
        end else begin
          if (cyc == MID)
            sample_bit();
          cyc = (cyc == `USB_BIT_CYCLES - 1) ? 0 : cyc + 1;
        end
      end
    end
    done_count    <= n_done;
    error_count   <= n_err;
    pending_count <= exp_q.size() + err_pending;
    stall_count   <= stalls;
  end

endmodule

`default_nettype wire

// ==== dv/usb_tx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usb_tx_defs.svh"

module usb_tx_tb;

  localparam int N_ROWS = 12;

  typedef struct packed {
    logic [7:0] pid;
    logic [5:0] len;        // payload bytes
    logic       ones_fill;
    logic       bad;        // expect pid_error, nothing on the line
    logic       hold;       // next row goes out without waiting
  } row_t;

  logic                   clock = 1'b0;
  logic                   reset;
  logic                   req;
  usb_tx_pkg::host_byte_t wdata;
  logic                   ack;
  logic                   pid_error;
  usb_tx_pkg::line_t      line;
  logic                   busy;
  logic                   exp_valid;
  logic [7:0]             exp_data;
  logic                   exp_last;
  logic                   exp_err;
  int                     done_count;
  int                     error_count;
  int                     pending_count;
  int                     stall_count;
  row_t                   rows [N_ROWS];
  int                     cycles = 0;
  int                     limit;

  always #4 clock = ~clock;

  usb_tx_top u_usb_tx_top (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .wdata     (wdata),
    .ack       (ack),
    .pid_error (pid_error),
    .line      (line),
    .busy      (busy)
  );

  usb_tx_monitor u_usb_tx_monitor (
    .clock         (clock),
    .reset         (reset),
    .req           (req),
    .ack           (ack),
    .pid_error     (pid_error),
    .busy          (busy),
    .line          (line),
    .exp_valid     (exp_valid),
    .exp_data      (exp_data),
    .exp_last      (exp_last),
    .exp_err       (exp_err),
    .done_count    (done_count),
    .error_count   (error_count),
    .pending_count (pending_count),
    .stall_count   (stall_count)
  );

  task automatic load_table();
    rows[0]  = '{pid: `USB_PID_ACK,   len: 6'd0,  ones_fill: 1'b0, bad: 1'b0, hold: 1'b0};
    rows[1]  = '{pid: `USB_PID_DATA0, len: 6'd1,  ones_fill: 1'b0, bad: 1'b0, hold: 1'b0};
    rows[2]  = '{pid: `USB_PID_DATA1, len: 6'd32, ones_fill: 1'b0, bad: 1'b0, hold: 1'b0};
    rows[3]  = '{pid: `USB_PID_DATA0, len: 6'd16, ones_fill: 1'b1, bad: 1'b0, hold: 1'b0};
    rows[4]  = '{pid: 8'hC2,          len: 6'd3,  ones_fill: 1'b0, bad: 1'b1, hold: 1'b0};
    rows[5]  = '{pid: `USB_PID_DATA1, len: 6'd7,  ones_fill: 1'b0, bad: 1'b0, hold: 1'b0};
    rows[6]  = '{pid: 8'h00,          len: 6'd0,  ones_fill: 1'b0, bad: 1'b1, hold: 1'b0};
    // queued rows overrun the buffer while the first is on the line
    rows[7]  = '{pid: `USB_PID_DATA1, len: 6'd32, ones_fill: 1'b1, bad: 1'b0, hold: 1'b1};
    rows[8]  = '{pid: `USB_PID_DATA0, len: 6'd32, ones_fill: 1'b0, bad: 1'b0, hold: 1'b1};
    rows[9]  = '{pid: `USB_PID_DATA1, len: 6'd32, ones_fill: 1'b0, bad: 1'b0, hold: 1'b1};
    rows[10] = '{pid: `USB_PID_DATA0, len: 6'd24, ones_fill: 1'b0, bad: 1'b0, hold: 1'b1};
    rows[11] = '{pid: `USB_PID_ACK,   len: 6'd0,  ones_fill: 1'b0, bad: 1'b0, hold: 1'b0};
  endtask

  task automatic post_expect(input logic [7:0] data, input logic last, input logic err);
    exp_valid <= 1'b1;
    exp_data  <= data;
    exp_last  <= last;
    exp_err   <= err;
    @(posedge clock);
  endtask

  // one four-phase transfer
  task automatic send_byte(input logic [7:0] data);
    req   <= 1'b1;
    wdata <= data;
    do @(posedge clock); while (!ack);
    req <= 1'b0;
    do @(posedge clock); while (ack);
  endtask

  task automatic run_row(input row_t row);
    logic [7:0] pkt [$];
    pkt.push_back(row.pid);
    for (int i = 0; i < int'(row.len); i++)
      pkt.push_back(row.ones_fill ? 8'hFF : 8'($urandom()));
    if (row.bad) begin
      post_expect(8'(pkt.size() + 1), 1'b1, 1'b1);  // ack count, length byte included
    end else begin
      foreach (pkt[i])
        post_expect(pkt[i], i == pkt.size() - 1, 1'b0);
    end
    exp_valid <= 1'b0;
    send_byte(8'(pkt.size()));  // length counts the pid
    foreach (pkt[i])
      send_byte(pkt[i]);
  endtask

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: run hung after %0d cycles with %0d of %0d tests done",
               cycles, done_count, N_ROWS);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(71));
    load_table();
    limit = 200;
    foreach (rows[r])
      limit += (int'(rows[r].len) + 1 + 5) * 10 * `USB_BIT_CYCLES;
    reset     = 1'b1;
    req       = 1'b0;
    wdata     = '0;
    exp_valid = 1'b0;
    exp_data  = '0;
    exp_last  = 1'b0;
    exp_err   = 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    for (int r = 0; r < N_ROWS; r++) begin
      run_row(rows[r]);
      if (!rows[r].hold) begin
        while (done_count < r + 1 || busy)
          @(posedge clock);
      end
    end
    repeat (4) @(posedge clock);
    if (stall_count == 0)
      $display("error: ack never stalled while rows were queued");
    $display("tests %0d of %0d done, %0d errors, %0d expectations left, %0d ack stall cycles",
             done_count, N_ROWS, error_count, pending_count, stall_count);
    if (error_count == 0 && pending_count == 0 && done_count == N_ROWS && stall_count > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/host_write_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usb_tx_defs.svh"

module host_write_port (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   req,
  input  usb_tx_pkg::host_byte_t wdata,
  output logic                   ack,
  output logic                   pid_error,
  output logic                   push,
  output usb_tx_pkg::buf_entry_t entry,
  input  logic                   ready
);

  localparam int REM_W = $clog2(`USB_MAX_PAYLOAD + 2);

  typedef enum logic [1:0] {PH_LEN, PH_PID, PH_DATA} phase_t;

  phase_t                 phase;
  logic [REM_W-1:0]       rem;        // bytes still owed
  usb_tx_pkg::pid_t       pid_in;
  logic                   pid_good;
  logic                   pid_ok;
  logic                   accept;
  logic                   last_in;
  logic                   take;       // non-length byte accepted last cycle
  logic                   take_pid;
  logic                   held;       // pid waiting for its first payload
  logic                   pend_data;
  logic                   last_q;
  usb_tx_pkg::host_byte_t byte_q;
  usb_tx_pkg::host_byte_t pid_hold;

  assign pid_in   = wdata;
  assign pid_good = (pid_in.f.check == ~pid_in.f.pid_type);
  // length byte never waits on the buffer
  assign accept   = req && !ack && (phase == PH_LEN || ready);
  assign last_in  = (rem == REM_W'(1));

  always_ff @(posedge clock) begin
    if (accept) begin
      byte_q   <= wdata;
      last_q   <= last_in;
      take_pid <= (phase == PH_PID);
      if (phase == PH_PID)
        pid_hold <= wdata;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ack       <= 1'b0;
      pid_error <= 1'b0;
      phase     <= PH_LEN;
      rem       <= '0;
      pid_ok    <= 1'b0;
      take      <= 1'b0;
      held      <= 1'b0;
      pend_data <= 1'b0;
      push      <= 1'b0;
      entry     <= '0;
    end else begin
      pid_error <= 1'b0;
      take      <= accept && (phase != PH_LEN);
      if (accept) begin
        ack <= 1'b1;
        case (phase)
          PH_LEN: begin
            rem <= wdata[REM_W-1:0];
            if (wdata != '0)
              phase <= PH_PID;
          end
          PH_PID: begin
            rem    <= rem - REM_W'(1);
            pid_ok <= pid_good;
            held   <= 1'b1;
            if (last_in) begin
              phase     <= PH_LEN;
              pid_error <= !pid_good;
            end else begin
              phase <= PH_DATA;
            end
          end
          default: begin
            rem <= rem - REM_W'(1);
            if (last_in) begin
              phase     <= PH_LEN;
              pid_error <= !pid_ok;
            end
          end
        endcase
      end else if (ack && !req) begin
        ack <= 1'b0;
      end

      // writes into the buffer, one cycle behind ack
      push <= 1'b0;
      if (pend_data) begin
        push      <= 1'b1;
        entry     <= '{data: byte_q, last: last_q, pid: 1'b0};
        pend_data <= 1'b0;
      end else if (take && pid_ok) begin
        if (take_pid) begin
          if (last_q) begin  // pid-only packet
            push  <= 1'b1;
            entry <= '{data: pid_hold, last: 1'b1, pid: 1'b1};
            held  <= 1'b0;
          end
        end else if (held) begin
          push      <= 1'b1;
          entry     <= '{data: pid_hold, last: 1'b0, pid: 1'b1};
          held      <= 1'b0;
          pend_data <= 1'b1;  // payload byte follows next cycle
        end else begin
          push  <= 1'b1;
          entry <= '{data: byte_q, last: last_q, pid: 1'b0};
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/line_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usb_tx_defs.svh"

module line_serializer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   pkt_ready,
  input  usb_tx_pkg::buf_entry_t head,
  output logic                   pop,
  output usb_tx_pkg::line_t      line,
  output logic                   busy
);

  localparam int CW = $clog2(`USB_BIT_CYCLES + 1);
  localparam int OW = $clog2(`USB_STUFF_LIMIT + 1);

  localparam usb_tx_pkg::line_t LINE_SE0 = '{drive: 1'b1, dp: 1'b0, dm: 1'b0};

  // state names the source of the bit sent at the next tick
  typedef enum logic [3:0] {
    S_IDLE, S_SYNC, S_PID, S_DATA, S_CRC_LO, S_CRC_HI,
    S_EOP, S_SE0, S_JTAIL, S_REL
  } state_t;

  state_t           state;
  logic [CW-1:0]    cyc;
  logic             tick;
  logic [OW-1:0]    ones;       // run of ones for stuffing
  logic             stuff;
  logic [2:0]       bit_idx;
  logic [7:0]       sh;
  logic             lvl;        // nrzi level, high is J
  logic             next_lvl;
  logic             is_data;
  logic             last_r;     // byte in sh ends the packet
  logic [15:0]      crc;
  logic [15:0]      crc_next;
  logic [15:0]      crc_upd;
  usb_tx_pkg::pid_t head_pid;

  function automatic usb_tx_pkg::line_t drive_level(input logic lvl_in);
    return '{drive: 1'b1, dp: lvl_in, dm: ~lvl_in};
  endfunction

  assign tick     = (cyc == CW'(`USB_BIT_CYCLES - 1));
  assign stuff    = (ones == OW'(`USB_STUFF_LIMIT));
  assign next_lvl = (stuff || !sh[0]) ? ~lvl : lvl;  // zero toggles
  assign head_pid = head.data;

  assign crc_next = {1'b0, crc[15:1]} ^ ((crc[0] ^ sh[0]) ? `USB_CRC16_POLY : 16'h0000);
  assign crc_upd  = (state == S_DATA) ? crc_next : crc;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= S_IDLE;
      busy  <= 1'b0;
      pop   <= 1'b0;
      line  <= '0;
      cyc   <= '0;
    end else begin
      pop <= 1'b0;
      if (state == S_IDLE) begin
        if (pkt_ready) begin
          // first bit period is the J lead, sh already holds SYNC
          state   <= S_SYNC;
          busy    <= 1'b1;
          cyc     <= '0;
          ones    <= '0;
          bit_idx <= '0;
          sh      <= `USB_SYNC_BYTE;
          crc     <= `USB_CRC16_INIT;
          lvl     <= 1'b1;
          line    <= drive_level(1'b1);
        end
      end else if (!tick) begin
        cyc <= cyc + CW'(1);
      end else begin
        cyc <= '0;
        case (state)
          S_SE0: state <= S_JTAIL;  // second SE0 bit
          S_JTAIL: begin
            line  <= drive_level(1'b1);
            state <= S_REL;
          end
          S_REL: begin
            line  <= '0;
            busy  <= 1'b0;
            state <= S_IDLE;
          end
          default: begin
            if (stuff || state != S_EOP) begin
              lvl  <= next_lvl;
              line <= drive_level(next_lvl);
              ones <= (stuff || !sh[0]) ? '0 : ones + OW'(1);
            end
            if (!stuff) begin
              if (state == S_EOP) begin
                line  <= LINE_SE0;
                state <= S_SE0;
              end else begin
                if (state == S_DATA)
                  crc <= crc_next;
                if (bit_idx != 3'd7) begin
                  sh      <= sh >> 1;
                  bit_idx <= bit_idx + 3'd1;
                end else begin
                  bit_idx <= '0;
                  case (state)
                    S_SYNC: begin
                      sh      <= head_pid.raw;
                      is_data <= (head_pid.f.pid_type[1:0] == `USB_PID_TYPE_DATA);
                      last_r  <= head.last;
                      pop     <= 1'b1;
                      state   <= S_PID;
                    end
                    S_PID, S_DATA: begin
                      if (!last_r) begin
                        sh     <= head.data;
                        last_r <= head.last;
                        pop    <= 1'b1;
                        state  <= S_DATA;
                      end else if (is_data) begin
                        sh    <= ~crc_upd[7:0];  // crc goes out inverted
                        state <= S_CRC_LO;
                      end else begin
                        state <= S_EOP;
                      end
                    end
                    S_CRC_LO: begin
                      sh    <= ~crc[15:8];
                      state <= S_CRC_HI;
                    end
                    default: state <= S_EOP;
                  endcase
                end
              end
            end
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/packet_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usb_tx_defs.svh"

module packet_buffer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   push,
  input  usb_tx_pkg::buf_entry_t entry,
  output logic                   ready,
  input  logic                   pop,
  output usb_tx_pkg::buf_entry_t head,
  output logic                   pkt_ready
);

  localparam int DEPTH = `USB_BUF_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  usb_tx_pkg::buf_entry_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic [AW:0]   pkt_count;  // whole packets stored
  logic          push_last;
  logic          pop_last;

  assign push_last = push && entry.last;
  assign pop_last  = pop && head.last;

  assign head      = mem[rd_ptr];
  // keep room for a held pid plus its first payload byte
  assign ready     = (count <= (AW+1)'(DEPTH - 2));
  assign pkt_ready = (pkt_count != '0);

  always_ff @(posedge clock) begin
    if (push)
      mem[wr_ptr] <= entry;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      pkt_count <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + AW'(1);
      if (pop)
        rd_ptr <= rd_ptr + AW'(1);
      count     <= count + (AW+1)'(push) - (AW+1)'(pop);
      pkt_count <= pkt_count + (AW+1)'(push_last) - (AW+1)'(pop_last);
    end
  end

endmodule

`default_nettype wire

// ==== hw/usb_tx_defs.svh ====
`ifndef USB_TX_DEFS_SVH
`define USB_TX_DEFS_SVH

// line timing
`define USB_BIT_CYCLES 4

// queue and packet limits
`define USB_BUF_DEPTH 64
`define USB_MAX_PAYLOAD 32

// ones before a stuffed zero
`define USB_STUFF_LIMIT 6

`define USB_SYNC_BYTE 8'h80

// pid values as sent on the wire
`define USB_PID_DATA0 8'hC3
`define USB_PID_DATA1 8'h4B
`define USB_PID_ACK 8'hD2
`define USB_PID_TYPE_DATA 2'b11

// crc16, reflected form of 0x8005
`define USB_CRC16_POLY 16'hA001
`define USB_CRC16_INIT 16'hFFFF

`endif

// ==== hw/usb_tx_pkg.sv ====
`default_nettype none

package usb_tx_pkg;

  typedef logic [7:0] host_byte_t;

  // check nibble carries the inverted type nibble
  typedef struct packed {
    logic [3:0] check;
    logic [3:0] pid_type;
  } pid_fields_t;

  // same pid byte, raw or split into nibbles
  typedef union packed {
    logic [7:0]  raw;
    pid_fields_t f;
  } pid_t;

  typedef struct packed {
    logic [7:0] data;
    logic       last;  // final byte of a packet
    logic       pid;   // first byte of a packet
  } buf_entry_t;

  typedef struct packed {
    logic drive;  // low means released
    logic dp;
    logic dm;
  } line_t;

endpackage

`default_nettype wire

// ==== hw/usb_tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_tx_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   req,
  input  usb_tx_pkg::host_byte_t wdata,
  output logic                   ack,
  output logic                   pid_error,
  output usb_tx_pkg::line_t      line,
  output logic                   busy
);

  logic                   push;
  logic                   ready;
  logic                   pop;
  logic                   pkt_ready;
  usb_tx_pkg::buf_entry_t push_entry;
  usb_tx_pkg::buf_entry_t head_entry;

  host_write_port u_host_write_port (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .wdata     (wdata),
    .ack       (ack),
    .pid_error (pid_error),
    .push      (push),
    .entry     (push_entry),
    .ready     (ready)
  );

  packet_buffer u_packet_buffer (
    .clock     (clock),
    .reset     (reset),
    .push      (push),
    .entry     (push_entry),
    .ready     (ready),
    .pop       (pop),
    .head      (head_entry),
    .pkt_ready (pkt_ready)
  );

  line_serializer u_line_serializer (
    .clock     (clock),
    .reset     (reset),
    .pkt_ready (pkt_ready),
    .head      (head_entry),
    .pop       (pop),
    .line      (line),
    .busy      (busy)
  );

endmodule

`default_nettype wire

// ==== usb_tx_top.f ====
+incdir+hw
hw/usb_tx_pkg.sv
hw/host_write_port.sv
hw/packet_buffer.sv
hw/line_serializer.sv
hw/usb_tx_top.sv
dv/usb_tx_monitor.sv
dv/usb_tx_tb.sv
